/* project.f */
design/frontend_pkg.sv
design/queue_wr_if.sv
design/queue_rd_if.sv
design/fetch_pack.sv
design/inst_queue.sv
design/issue_decode.sv
design/frontend_queue.sv
verif/frontend_queue_tb.sv

/* Bender.yml */
package:
  name: frontend_queue

sources:
  - design/frontend_pkg.sv
  - design/queue_wr_if.sv
  - design/queue_rd_if.sv
  - design/fetch_pack.sv
  - design/inst_queue.sv
  - design/issue_decode.sv
  - design/frontend_queue.sv
  - target: test
    files:
      - verif/frontend_queue_tb.sv

/* verif/frontend_queue_tb.sv */
module frontend_queue_tb;
    typedef enum {M_DUAL, M_SINGLE, M_HOLD, M_DRAIN, M_ONE, M_FLUSH, M_MIX} mode_t;

    localparam int STIM_CYCLES = 40 + 40 + 30 + 30 + 40 + 12 + 1 + 10 + 20 + 300 + 30;
    localparam int MAX_CYCLES  = 2 * STIM_CYCLES + 100;

    logic                          clk;
    logic                          rst;
    logic                          flush;
    logic                          fetch_valid;
    frontend_pkg::xlen_t           fetch_pc;
    frontend_pkg::xlen_t           fetch_instr_1;
    frontend_pkg::xlen_t           fetch_instr_2;
    logic                          fetch_pred_taken;
    frontend_pkg::xlen_t           fetch_pred_target;
    logic                          fetch_fault;
    logic                          fetch_stall;
    logic [1:0]                    issue_slots;
    logic                          dec_valid_1;
    frontend_pkg::xlen_t           dec_pc_1;
    frontend_pkg::opcode_t         dec_op_1;
    frontend_pkg::reg_idx_t        dec_rd_1;
    frontend_pkg::reg_idx_t        dec_rs1_1;
    frontend_pkg::reg_idx_t        dec_rs2_1;
    frontend_pkg::xlen_t           dec_imm_1;
    logic                          dec_pred_taken_1;
    frontend_pkg::exc_t            dec_exc_1;
    logic                          dec_valid_2;
    frontend_pkg::xlen_t           dec_pc_2;
    frontend_pkg::opcode_t         dec_op_2;
    frontend_pkg::reg_idx_t        dec_rd_2;
    frontend_pkg::reg_idx_t        dec_rs1_2;
    frontend_pkg::reg_idx_t        dec_rs2_2;
    frontend_pkg::xlen_t           dec_imm_2;
    logic                          dec_pred_taken_2;
    frontend_pkg::exc_t            dec_exc_2;

    frontend_pkg::entry_t          model [$];
    logic [31:0]                   seed       = 32'hbda9_7bae;
    int                            cycles     = 0;
    int                            stall_hits = 0;
    logic                          clear_seen = 1'b0;
    logic [1:0]                    slots_seen = 2'd0;
    // last one is not a real opcode.
    frontend_pkg::opcode_t op_table [10] = '{
        frontend_pkg::OP_LUI, frontend_pkg::OP_AUIPC, frontend_pkg::OP_JAL,
        frontend_pkg::OP_JALR, frontend_pkg::OP_BRANCH, frontend_pkg::OP_LOAD,
        frontend_pkg::OP_STORE, frontend_pkg::OP_IMM, frontend_pkg::OP_REG, 7'b1111111
    };

    frontend_queue frontend_queue_i (
        .clk (clk), .rst (rst), .flush (flush),
        .fetch_valid (fetch_valid), .fetch_pc (fetch_pc),
        .fetch_instr_1 (fetch_instr_1), .fetch_instr_2 (fetch_instr_2),
        .fetch_pred_taken (fetch_pred_taken), .fetch_pred_target (fetch_pred_target),
        .fetch_fault (fetch_fault), .fetch_stall (fetch_stall), .issue_slots (issue_slots),
        .dec_valid_1 (dec_valid_1), .dec_pc_1 (dec_pc_1), .dec_op_1 (dec_op_1),
        .dec_rd_1 (dec_rd_1), .dec_rs1_1 (dec_rs1_1), .dec_rs2_1 (dec_rs2_1),
        .dec_imm_1 (dec_imm_1), .dec_pred_taken_1 (dec_pred_taken_1), .dec_exc_1 (dec_exc_1),
        .dec_valid_2 (dec_valid_2), .dec_pc_2 (dec_pc_2), .dec_op_2 (dec_op_2),
        .dec_rd_2 (dec_rd_2), .dec_rs1_2 (dec_rs1_2), .dec_rs2_2 (dec_rs2_2),
        .dec_imm_2 (dec_imm_2), .dec_pred_taken_2 (dec_pred_taken_2), .dec_exc_2 (dec_exc_2)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = seed;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        seed = x;
        return x;
    endfunction

    function automatic frontend_pkg::xlen_t make_instr();
        logic [31:0] r;
        r = next_rand();
        return {r[31:7], op_table[r[3:0] % 10]};
    endfunction

    // expected queue entries of one accepted bundle; returns how many.
    function automatic int pack_ref(input frontend_pkg::xlen_t pc, input frontend_pkg::xlen_t i1,
                                    input frontend_pkg::xlen_t i2, input frontend_pkg::xlen_t tgt,
                                    input logic tk, input logic flt,
                                    output frontend_pkg::entry_t e1,
                                    output frontend_pkg::entry_t e2);
        frontend_pkg::exc_t ex;
        logic               two;
        if (flt) ex = frontend_pkg::EXC_FAULT;
        else if (pc[1:0] != 2'b00) ex = frontend_pkg::EXC_MISALIGN;
        else ex = frontend_pkg::EXC_NONE;
        two = (ex == frontend_pkg::EXC_NONE) && !pc[2];
        e1 = {pc, i1, 32'h0, 1'b0, ex};
        e2 = {pc + 32'd4, i2, 32'h0, 1'b0, ex};
        if (tk && two) e2 = {pc + 32'd4, i2, tgt, 1'b1, ex};
        else if (tk) e1 = {pc, i1, tgt, 1'b1, ex};
        return two ? 2 : 1;
    endfunction

    function automatic void decode_ref(input frontend_pkg::xlen_t ins,
                                       output frontend_pkg::opcode_t op,
                                       output frontend_pkg::reg_idx_t rd,
                                       output frontend_pkg::reg_idx_t rs1,
                                       output frontend_pkg::reg_idx_t rs2,
                                       output frontend_pkg::xlen_t imm);
        op  = ins[6:0];
        rd  = ins[11:7];
        rs1 = ins[19:15];
        rs2 = ins[24:20];
        case (op)
            frontend_pkg::OP_LOAD, frontend_pkg::OP_IMM, frontend_pkg::OP_JALR:
                imm = $signed(ins) >>> 20;
            frontend_pkg::OP_STORE:
                imm = $signed({ins[31:25], ins[11:7], 20'd0}) >>> 20;
            frontend_pkg::OP_BRANCH:  // 13-bit offset with low bit zero.
                imm = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0, 19'd0}) >>> 19;
            frontend_pkg::OP_LUI, frontend_pkg::OP_AUIPC:
                imm = {ins[31:12], 12'd0};
            frontend_pkg::OP_JAL:
                imm = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0, 11'd0}) >>> 11;
            default:
                imm = '0;
        endcase
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_xlen(input string what, input frontend_pkg::xlen_t got,
                              input frontend_pkg::xlen_t exp);
        if (got !== exp)
            stop_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_op(input string what, input frontend_pkg::opcode_t got,
                            input frontend_pkg::opcode_t exp);
        if (got !== exp)
            stop_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_reg(input string what, input frontend_pkg::reg_idx_t got,
                             input frontend_pkg::reg_idx_t exp);
        if (got !== exp)
            stop_run($sformatf("ERR %0t: %s is x%0d, expected x%0d", $time, what, got, exp));
    endtask

    task automatic check_exc(input string what, input frontend_pkg::exc_t got,
                             input frontend_pkg::exc_t exp);
        if (got !== exp)
            stop_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_slot(input int k, input frontend_pkg::entry_t e,
                              input frontend_pkg::xlen_t pc, input frontend_pkg::opcode_t op,
                              input frontend_pkg::reg_idx_t rd,
                              input frontend_pkg::reg_idx_t rs1,
                              input frontend_pkg::reg_idx_t rs2,
                              input frontend_pkg::xlen_t imm, input logic tk,
                              input frontend_pkg::exc_t exc);
        frontend_pkg::opcode_t  x_op;
        frontend_pkg::reg_idx_t x_rd;
        frontend_pkg::reg_idx_t x_rs1;
        frontend_pkg::reg_idx_t x_rs2;
        frontend_pkg::xlen_t    x_imm;
        decode_ref(e[66:35], x_op, x_rd, x_rs1, x_rs2, x_imm);
        check_xlen($sformatf("slot %0d pc", k), pc, e[98:67]);
        check_op($sformatf("slot %0d opcode", k), op, x_op);
        check_reg($sformatf("slot %0d rd", k), rd, x_rd);
        check_reg($sformatf("slot %0d rs1", k), rs1, x_rs1);
        check_reg($sformatf("slot %0d rs2", k), rs2, x_rs2);
        check_xlen($sformatf("slot %0d imm", k), imm, x_imm);
        check_bit($sformatf("slot %0d taken", k), tk, e[2]);
        check_exc($sformatf("slot %0d exc", k), exc, e[1:0]);
    endtask

    task automatic run_phase(input mode_t mode, input int n_cycles);
        logic [31:0] r;
        for (int c = 0; c < n_cycles; c++) begin
            r = next_rand();
            @(posedge clk);
            fetch_valid       <= (mode != M_DRAIN);
            fetch_pc          <= {r[31:3], 3'b000};
            fetch_instr_1     <= make_instr();
            fetch_instr_2     <= make_instr();
            fetch_pred_target <= next_rand();
            fetch_pred_taken  <= r[0];
            fetch_fault       <= 1'b0;
            issue_slots       <= 2'd2;
            flush             <= 1'b0;
            case (mode)
                M_SINGLE: begin
                    case (r[4:3])
                        2'd0: fetch_pc <= {r[31:3], 3'b100};  // slot 1 of the pair.
                        2'd1: fetch_pc <= {r[31:3], r[5], 2'b01};
                        2'd2: fetch_fault <= 1'b1;
                        default: fetch_pc <= {r[31:3], r[5], 2'b10};
                    endcase
                end
                M_HOLD: issue_slots <= 2'd0;
                M_ONE: issue_slots <= 2'd1;
                M_FLUSH: flush <= 1'b1;
                M_MIX: begin
                    fetch_valid <= r[5] | r[6];
                    fetch_pc    <= {r[31:3], r[9] ? r[2:0] : 3'b000};
                    fetch_fault <= (r[10:8] == 3'd0);
                    issue_slots <= (r[12:11] == 2'd3) ? 2'd2 : r[12:11];
                    flush       <= (r[17:13] == 5'd0);
                end
                default: ;
            endcase
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
            stop_run($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
    end

    // negedge sampling; inputs and outputs are settled here.
    always @(negedge clk) begin : scoreboard
        frontend_pkg::entry_t e1;
        frontend_pkg::entry_t e2;
        frontend_pkg::entry_t head;
        int                   n;
        if (!rst) begin
            if (clear_seen) begin
                check_bit("fetch_stall after reset or flush", fetch_stall, 1'b0);
                check_bit("dec_valid_1 after reset or flush", dec_valid_1, 1'b0);
                check_bit("dec_valid_2 after reset or flush", dec_valid_2, 1'b0);
            end
            if (slots_seen < 2'd2) check_bit("dec_valid_2 beyond issue_slots", dec_valid_2, 1'b0);
            if (slots_seen == 2'd0) check_bit("dec_valid_1 with no slots", dec_valid_1, 1'b0);
            if (dec_valid_1) begin
                if (model.size() == 0) begin
                    stop_run("slot 1 delivered an entry that was never accepted");
                end else begin
                    head = model.pop_front();
                    check_slot(1, head, dec_pc_1, dec_op_1, dec_rd_1, dec_rs1_1, dec_rs2_1,
                               dec_imm_1, dec_pred_taken_1, dec_exc_1);
                end
            end
            if (dec_valid_2) begin
                if (model.size() == 0) begin
                    stop_run("slot 2 delivered an entry that was never accepted");
                end else begin
                    head = model.pop_front();
                    check_slot(2, head, dec_pc_2, dec_op_2, dec_rd_2, dec_rs1_2, dec_rs2_2,
                               dec_imm_2, dec_pred_taken_2, dec_exc_2);
                end
            end
            if (fetch_stall) stall_hits++;
            if (flush) begin
                model.delete();  // everything in flight is dropped.
            end else if (fetch_valid && !fetch_stall) begin
                n = pack_ref(fetch_pc, fetch_instr_1, fetch_instr_2, fetch_pred_target,
                             fetch_pred_taken, fetch_fault, e1, e2);
                model.push_back(e1);
                if (n == 2) model.push_back(e2);
            end
        end
        clear_seen = flush | rst;
        slots_seen = issue_slots;
    end

    initial begin
        int hits_before;
        rst               = 1'b1;
        flush             = 1'b0;
        fetch_valid       = 1'b0;
        fetch_pc          = '0;
        fetch_instr_1     = '0;
        fetch_instr_2     = '0;
        fetch_pred_taken  = 1'b0;
        fetch_pred_target = '0;
        fetch_fault       = 1'b0;
        issue_slots       = 2'd0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        run_phase(M_DUAL, 40);
        run_phase(M_SINGLE, 40);
        hits_before = stall_hits;
        run_phase(M_HOLD, 30);
        if (stall_hits == hits_before) stop_run("fetch_stall never rose while the queue was held");
        run_phase(M_DRAIN, 30);
        run_phase(M_ONE, 40);
        run_phase(M_HOLD, 12);  // fill and then flush it all.
        run_phase(M_FLUSH, 1);
        run_phase(M_DUAL, 10);
        run_phase(M_DRAIN, 20);
        run_phase(M_MIX, 300);
        run_phase(M_DRAIN, 30);
        @(posedge clk);
        if (model.size() != 0) begin
            stop_run($sformatf("%0d accepted entries never came out", model.size()));
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* design/frontend_queue.sv */
module frontend_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     fetch_valid,
    input  frontend_pkg::xlen_t      fetch_pc,
    input  frontend_pkg::xlen_t      fetch_instr_1,
    input  frontend_pkg::xlen_t      fetch_instr_2,
    input  logic                     fetch_pred_taken,
    input  frontend_pkg::xlen_t      fetch_pred_target,
    input  logic                     fetch_fault,
    output logic                     fetch_stall,
    input  logic [1:0]               issue_slots,
    output logic                     dec_valid_1,
    output frontend_pkg::xlen_t      dec_pc_1,
    output frontend_pkg::opcode_t    dec_op_1,
    output frontend_pkg::reg_idx_t   dec_rd_1,
    output frontend_pkg::reg_idx_t   dec_rs1_1,
    output frontend_pkg::reg_idx_t   dec_rs2_1,
    output frontend_pkg::xlen_t      dec_imm_1,
    output logic                     dec_pred_taken_1,
    output frontend_pkg::exc_t       dec_exc_1,
    output logic                     dec_valid_2,
    output frontend_pkg::xlen_t      dec_pc_2,
    output frontend_pkg::opcode_t    dec_op_2,
    output frontend_pkg::reg_idx_t   dec_rd_2,
    output frontend_pkg::reg_idx_t   dec_rs1_2,
    output frontend_pkg::reg_idx_t   dec_rs2_2,
    output frontend_pkg::xlen_t      dec_imm_2,
    output logic                     dec_pred_taken_2,
    output frontend_pkg::exc_t       dec_exc_2
);
    queue_wr_if wr_if ();
    queue_rd_if rd_if ();

    assign fetch_stall = wr_if.stall;

    fetch_pack fetch_pack_i (
        .clk               (clk),
        .rst               (rst),
        .flush             (flush),
        .fetch_valid       (fetch_valid),
        .fetch_pc          (fetch_pc),
        .fetch_instr_1     (fetch_instr_1),
        .fetch_instr_2     (fetch_instr_2),
        .fetch_pred_target (fetch_pred_target),
        .fetch_pred_taken  (fetch_pred_taken),
        .fetch_fault       (fetch_fault),
        .wr                (wr_if.packer)
    );

    inst_queue inst_queue_i (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .wr    (wr_if.queue),
        .rd    (rd_if.queue)
    );

    issue_decode issue_decode_i (
        .clk              (clk),
        .rst              (rst),
        .flush            (flush),
        .issue_slots      (issue_slots),
        .rd               (rd_if.issue),
        .dec_valid_1      (dec_valid_1),
        .dec_pc_1         (dec_pc_1),
        .dec_op_1         (dec_op_1),
        .dec_rd_1         (dec_rd_1),
        .dec_rs1_1        (dec_rs1_1),
        .dec_rs2_1        (dec_rs2_1),
        .dec_imm_1        (dec_imm_1),
        .dec_pred_taken_1 (dec_pred_taken_1),
        .dec_exc_1        (dec_exc_1),
        .dec_valid_2      (dec_valid_2),
        .dec_pc_2         (dec_pc_2),
        .dec_op_2         (dec_op_2),
        .dec_rd_2         (dec_rd_2),
        .dec_rs1_2        (dec_rs1_2),
        .dec_rs2_2        (dec_rs2_2),
        .dec_imm_2        (dec_imm_2),
        .dec_pred_taken_2 (dec_pred_taken_2),
        .dec_exc_2        (dec_exc_2)
    );

endmodule

/* design/issue_decode.sv */
module issue_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic [1:0]               issue_slots,
    queue_rd_if.issue                rd,
    output logic                     dec_valid_1,
    output frontend_pkg::xlen_t      dec_pc_1,
    output frontend_pkg::opcode_t    dec_op_1,
    output frontend_pkg::reg_idx_t   dec_rd_1,
    output frontend_pkg::reg_idx_t   dec_rs1_1,
    output frontend_pkg::reg_idx_t   dec_rs2_1,
    output frontend_pkg::xlen_t      dec_imm_1,
    output logic                     dec_pred_taken_1,
    output frontend_pkg::exc_t       dec_exc_1,
    output logic                     dec_valid_2,
    output frontend_pkg::xlen_t      dec_pc_2,
    output frontend_pkg::opcode_t    dec_op_2,
    output frontend_pkg::reg_idx_t   dec_rd_2,
    output frontend_pkg::reg_idx_t   dec_rs1_2,
    output frontend_pkg::reg_idx_t   dec_rs2_2,
    output frontend_pkg::xlen_t      dec_imm_2,
    output logic                     dec_pred_taken_2,
    output frontend_pkg::exc_t       dec_exc_2
);
    logic [1:0]          avail;
    logic [1:0]          n_pop;
    frontend_pkg::xlen_t instr_1;
    frontend_pkg::xlen_t instr_2;

    // sign-extended immediate by format.
    function automatic frontend_pkg::xlen_t imm_gen(input frontend_pkg::xlen_t ins);
        frontend_pkg::xlen_t imm;
        case (frontend_pkg::opcode_t'(ins[6:0]))
            frontend_pkg::OP_LOAD, frontend_pkg::OP_IMM, frontend_pkg::OP_JALR:
                imm = {{20{ins[31]}}, ins[31:20]};
            frontend_pkg::OP_STORE:
                imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            frontend_pkg::OP_BRANCH:
                imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            frontend_pkg::OP_LUI, frontend_pkg::OP_AUIPC:
                imm = {ins[31:12], 12'b0};
            frontend_pkg::OP_JAL:
                imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            frontend_pkg::OP_REG:
                imm = '0;  // no immediate.
            default:
                imm = '0;
        endcase
        return imm;
    endfunction

    assign avail    = {1'b0, rd.ok_1} + {1'b0, rd.ok_2};
    assign n_pop    = (issue_slots < avail) ? issue_slots : avail;
    assign rd.pop_1 = (n_pop != 2'd0);
    assign rd.pop_2 = (n_pop == 2'd2);

    assign instr_1 = rd.data_1[frontend_pkg::INSTR_LSB +: frontend_pkg::XLEN];
    assign instr_2 = rd.data_2[frontend_pkg::INSTR_LSB +: frontend_pkg::XLEN];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dec_valid_1 <= 1'b0;
            dec_valid_2 <= 1'b0;
        end else begin
            dec_valid_1 <= rd.pop_1;
            dec_valid_2 <= rd.pop_2;
        end
    end

    always_ff @(posedge clk) begin
        if (rd.pop_1) begin
            dec_pc_1         <= rd.data_1[frontend_pkg::PC_LSB +: frontend_pkg::XLEN];
            dec_op_1         <= instr_1[6:0];
            dec_rd_1         <= instr_1[11:7];
            dec_rs1_1        <= instr_1[19:15];
            dec_rs2_1        <= instr_1[24:20];
            dec_imm_1        <= imm_gen(instr_1);
            dec_pred_taken_1 <= rd.data_1[frontend_pkg::TAKEN_BIT];
            dec_exc_1        <= rd.data_1[frontend_pkg::EXC_W-1:0];
        end
        if (rd.pop_2) begin
            dec_pc_2         <= rd.data_2[frontend_pkg::PC_LSB +: frontend_pkg::XLEN];
            dec_op_2         <= instr_2[6:0];
            dec_rd_2         <= instr_2[11:7];
            dec_rs1_2        <= instr_2[19:15];
            dec_rs2_2        <= instr_2[24:20];
            dec_imm_2        <= imm_gen(instr_2);
            dec_pred_taken_2 <= rd.data_2[frontend_pkg::TAKEN_BIT];
            dec_exc_2        <= rd.data_2[frontend_pkg::EXC_W-1:0];
        end
    end

    a_slot_order: assert property (@(posedge clk) disable iff (rst)
        dec_valid_2 |-> dec_valid_1);

endmodule

/* design/inst_queue.sv */
module inst_queue (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    queue_wr_if.queue wr,
    queue_rd_if.queue rd
);
    localparam int IDX_W = frontend_pkg::PTR_W - 1;

    frontend_pkg::entry_t           mem [frontend_pkg::QUEUE_DEPTH];
    frontend_pkg::entry_t           wait_reg_1;
    frontend_pkg::entry_t           wait_reg_2;
    frontend_pkg::q_state_t         state;
    frontend_pkg::q_state_t         state_nxt;
    logic [frontend_pkg::PTR_W-1:0] w_ptr;
    logic [frontend_pkg::PTR_W-1:0] r_ptr;
    logic [frontend_pkg::PTR_W-1:0] w_ptr_p1;
    logic [frontend_pkg::PTR_W-1:0] r_ptr_p1;
    logic [frontend_pkg::PTR_W-1:0] count;
    logic                           full;
    logic                           left_one;
    logic                           push_1;
    logic                           push_2;
    logic [1:0]                     push_cnt;
    logic [1:0]                     pop_cnt;
    frontend_pkg::entry_t           push_data_1;
    frontend_pkg::entry_t           push_data_2;
    logic                           wait_ld_1;
    logic                           wait_ld_2;
    frontend_pkg::entry_t           wait_data_1;

    assign w_ptr_p1 = w_ptr + 1'b1;
    assign r_ptr_p1 = r_ptr + 1'b1;
    assign count    = w_ptr - r_ptr;  // wrap bit keeps 0 and depth apart.
    assign full     = (count == frontend_pkg::PTR_W'(frontend_pkg::QUEUE_DEPTH));
    assign left_one = (count == frontend_pkg::PTR_W'(frontend_pkg::QUEUE_DEPTH - 1));

    assign rd.ok_1   = (count != '0) & ~flush;
    assign rd.ok_2   = (count > frontend_pkg::PTR_W'(1)) & ~flush;
    assign rd.data_1 = mem[r_ptr[IDX_W-1:0]];
    assign rd.data_2 = mem[r_ptr_p1[IDX_W-1:0]];

    assign wr.stall = full | left_one;

    always_comb begin
        pop_cnt = 2'd0;
        if (rd.pop_1 && rd.pop_2) begin
            if (rd.ok_1 && rd.ok_2) pop_cnt = 2'd2;
        end else if (rd.pop_1 && rd.ok_1) begin
            pop_cnt = 2'd1;
        end
    end

    always_comb begin
        state_nxt   = state;
        push_1      = 1'b0;
        push_2      = 1'b0;
        push_data_1 = wr.data_1;
        push_data_2 = wr.data_2;
        wait_ld_1   = 1'b0;
        wait_ld_2   = 1'b0;
        wait_data_1 = wr.data_1;
        case (state)
            frontend_pkg::Q_NORMAL: begin
                if (wr.ena_1) begin
                    if (full) begin
                        wait_ld_1 = 1'b1;
                        wait_ld_2 = wr.ena_2;
                        state_nxt = wr.ena_2 ? frontend_pkg::Q_WAIT_2 : frontend_pkg::Q_WAIT_1;
                    end else if (left_one && wr.ena_2) begin
                        push_1      = 1'b1;
                        wait_ld_1   = 1'b1;
                        wait_data_1 = wr.data_2;  // second entry parks.
                        state_nxt   = frontend_pkg::Q_WAIT_1;
                    end else begin
                        push_1 = 1'b1;
                        push_2 = wr.ena_2;
                    end
                end
            end
            frontend_pkg::Q_WAIT_1: begin
                if (!full) begin
                    push_1      = 1'b1;
                    push_data_1 = wait_reg_1;
                    state_nxt   = frontend_pkg::Q_NORMAL;
                end
            end
            frontend_pkg::Q_WAIT_2: begin
                if (!full && !left_one) begin
                    push_1      = 1'b1;
                    push_2      = 1'b1;
                    push_data_1 = wait_reg_1;
                    push_data_2 = wait_reg_2;
                    state_nxt   = frontend_pkg::Q_NORMAL;
                end else if (left_one) begin
                    // one slot; older entry goes first.
                    push_1      = 1'b1;
                    push_data_1 = wait_reg_1;
                    wait_ld_1   = 1'b1;
                    wait_data_1 = wait_reg_2;
                    state_nxt   = frontend_pkg::Q_WAIT_1;
                end
            end
            default: state_nxt = frontend_pkg::Q_NORMAL;
        endcase
    end

    assign push_cnt = {1'b0, push_1} + {1'b0, push_2};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            w_ptr <= '0;
            r_ptr <= '0;
            state <= frontend_pkg::Q_NORMAL;
        end else begin
            w_ptr <= w_ptr + frontend_pkg::PTR_W'(push_cnt);
            r_ptr <= r_ptr + frontend_pkg::PTR_W'(pop_cnt);
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (push_1) mem[w_ptr[IDX_W-1:0]] <= push_data_1;
        if (push_2) mem[w_ptr_p1[IDX_W-1:0]] <= push_data_2;
        if (wait_ld_1) wait_reg_1 <= wait_data_1;
        if (wait_ld_2) wait_reg_2 <= wr.data_2;
    end

    a_pop_ok: assert property (@(posedge clk) disable iff (rst)
        (rd.pop_1 |-> rd.ok_1) and (rd.pop_2 |-> (rd.pop_1 && rd.ok_2)));

    a_ena_order: assert property (@(posedge clk) disable iff (rst)
        wr.ena_2 |-> wr.ena_1);

    a_count_max: assert property (@(posedge clk) disable iff (rst)
        count <= frontend_pkg::PTR_W'(frontend_pkg::QUEUE_DEPTH));

    // packer must honour the stall seen at the last edge.
    a_wait_no_write: assert property (@(posedge clk) disable iff (rst || flush)
        (state != frontend_pkg::Q_NORMAL && $past(wr.stall)) |-> !wr.ena_1);

endmodule

/* design/fetch_pack.sv */
module fetch_pack (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                fetch_valid,
    input  frontend_pkg::xlen_t fetch_pc,
    input  frontend_pkg::xlen_t fetch_instr_1,
    input  frontend_pkg::xlen_t fetch_instr_2,
    input  frontend_pkg::xlen_t fetch_pred_target,
    input  logic                fetch_pred_taken,
    input  logic                fetch_fault,
    queue_wr_if.packer          wr
);
    logic                bundle_vld;
    logic                take;
    frontend_pkg::xlen_t pc_q;
    frontend_pkg::xlen_t instr_1_q;
    frontend_pkg::xlen_t instr_2_q;
    frontend_pkg::xlen_t target_q;
    logic                taken_q;
    logic                fault_q;
    logic                dual;
    frontend_pkg::exc_t  exc;
    frontend_pkg::xlen_t pc_plus_4;
    frontend_pkg::xlen_t tgt_1;
    frontend_pkg::xlen_t tgt_2;
    logic                tk_1;
    logic                tk_2;

    assign take = fetch_valid & ~wr.stall;  // no new bundle under stall.

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            bundle_vld <= 1'b0;
        end else begin
            bundle_vld <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_q      <= fetch_pc;
            instr_1_q <= fetch_instr_1;
            instr_2_q <= fetch_instr_2;
            target_q  <= fetch_pred_target;
            taken_q   <= fetch_pred_taken;
            fault_q   <= fetch_fault;
        end
    end

    always_comb begin
        if (fault_q) exc = frontend_pkg::EXC_FAULT;
        else if (pc_q[1:0] != 2'b00) exc = frontend_pkg::EXC_MISALIGN;
        else exc = frontend_pkg::EXC_NONE;
    end

    // second slot only for an 8-byte aligned, clean bundle.
    assign dual      = (pc_q[2:0] == 3'b000) & ~fault_q;
    assign pc_plus_4 = pc_q + 32'd4;

    // prediction rides on the last valid slot.
    always_comb begin
        tgt_1 = '0;
        tk_1  = 1'b0;
        tgt_2 = '0;
        tk_2  = 1'b0;
        if (taken_q) begin
            if (dual) begin
                tgt_2 = target_q;
                tk_2  = 1'b1;
            end else begin
                tgt_1 = target_q;
                tk_1  = 1'b1;
            end
        end
    end

    assign wr.ena_1  = bundle_vld;
    assign wr.ena_2  = bundle_vld & dual;
    assign wr.data_1 = {pc_q, instr_1_q, tgt_1, tk_1, exc};
    assign wr.data_2 = {pc_plus_4, instr_2_q, tgt_2, tk_2, exc};

endmodule

/* design/queue_rd_if.sv */
interface queue_rd_if;
    frontend_pkg::entry_t data_1;  // head.
    frontend_pkg::entry_t data_2;  // head plus one.
    logic                 ok_1;
    logic                 ok_2;
    logic                 pop_1;
    logic                 pop_2;

    modport queue (
        output data_1,
        output data_2,
        output ok_1,
        output ok_2,
        input  pop_1,
        input  pop_2
    );

    modport issue (
        input  data_1,
        input  data_2,
        input  ok_1,
        input  ok_2,
        output pop_1,
        output pop_2
    );
endinterface

/* design/queue_wr_if.sv */
interface queue_wr_if;
    logic                 ena_1;
    logic                 ena_2;   // only with ena_1.
    frontend_pkg::entry_t data_1;
    frontend_pkg::entry_t data_2;
    logic                 stall;

    modport packer (
        output ena_1,
        output ena_2,
        output data_1,
        output data_2,
        input  stall
    );

    modport queue (
        input  ena_1,
        input  ena_2,
        input  data_1,
        input  data_2,
        output stall
    );
endinterface

/* design/frontend_pkg.sv */
package frontend_pkg;

    localparam int XLEN        = 32;
    localparam int EXC_W       = 2;
    localparam int ENTRY_W     = 99;
    localparam int QUEUE_DEPTH = 8;
    localparam int PTR_W       = $clog2(QUEUE_DEPTH) + 1;  // extra wrap bit.

    // entry layout, top bit down: pc, instr, target, taken, exc.
    localparam int PC_LSB    = 67;
    localparam int INSTR_LSB = 35;
    localparam int TAKEN_BIT = 2;

    typedef logic [XLEN-1:0]    xlen_t;
    typedef logic [EXC_W-1:0]   exc_t;
    typedef logic [ENTRY_W-1:0] entry_t;
    typedef logic [4:0]         reg_idx_t;
    typedef logic [6:0]         opcode_t;

    localparam exc_t EXC_NONE     = 2'd0;
    localparam exc_t EXC_MISALIGN = 2'd1;
    localparam exc_t EXC_FAULT    = 2'd2;

    typedef enum logic [1:0] {
        Q_NORMAL,
        Q_WAIT_1,
        Q_WAIT_2
    } q_state_t;

    // major opcodes.
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

endpackage
